// ==== verilog/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // shared word memory geometry
    localparam int MEM_WORDS = 1024;
    localparam int ADDR_W    = $clog2(MEM_WORDS);
    localparam int DATA_W    = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // requester tag, one bit per port
    typedef logic [0:0] port_t;
    localparam port_t PORT_HOST = 1'b0;
    localparam port_t PORT_DMA  = 1'b1;
    localparam int    NUM_PORTS = 2;

    // credit depths
    localparam int PORT_CREDITS    = 2;
    localparam int MEM_QUEUE_DEPTH = 4;
    localparam int PORT_PTR_W      = $clog2(PORT_CREDITS);
    localparam int MEM_PTR_W       = $clog2(MEM_QUEUE_DEPTH);

    // counters that reach the full depth need one extra bit
    typedef logic [$clog2(PORT_CREDITS+1)-1:0]    port_cred_t;
    typedef logic [$clog2(MEM_QUEUE_DEPTH+1)-1:0] mem_cred_t;

    // requester side, 44 bits
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t data;
    } mem_req_t;

    // arbiter to memory, carries the port tag, 45 bits
    typedef struct packed {
        logic  valid;
        logic  write;
        port_t port;
        addr_t addr;
        data_t data;
    } mem_tagged_req_t;

    // data is don't care on a write ack, 35 bits
    typedef struct packed {
        logic  valid;
        logic  write;
        port_t port;
        data_t data;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    // host register map
    typedef logic [2:0] reg_addr_t;
    localparam reg_addr_t REG_SRC    = 3'd0;
    localparam reg_addr_t REG_DST    = 3'd1;
    localparam reg_addr_t REG_LEN    = 3'd2;
    localparam reg_addr_t REG_CTRL   = 3'd3;
    localparam reg_addr_t REG_STATUS = 3'd4;

    // wide enough to copy the whole memory
    typedef logic [10:0] len_t;

    typedef struct packed {
        bus_pkg::addr_t src;
        bus_pkg::addr_t dst;
        len_t           len;
    } dma_cfg_t;

    // status word layout
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_COPY,
        DMA_FINISH
    } dma_state_t;

    // interrupt stretch, counter holds the cycles left after fin
    localparam int IRQ_HOLD_CYCLES = 3;
    typedef logic [$clog2(IRQ_HOLD_CYCLES)-1:0] irq_cnt_t;

    // engine read data buffer
    localparam int ENG_BUF_DEPTH = 4;
    localparam int ENG_PTR_W     = $clog2(ENG_BUF_DEPTH);
    typedef logic [ENG_PTR_W:0] buf_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/dma_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              reg_wr_i,
    input  dma_pkg::reg_addr_t reg_addr_i,
    input  bus_pkg::data_t    reg_wdata_i,
    output bus_pkg::data_t    reg_rdata_o,
    input  logic              busy_i,
    input  logic              fin_i,
    output logic              start_o,
    output dma_pkg::dma_cfg_t cfg_o,
    output logic              irq_o
);
    import bus_pkg::*;
    import dma_pkg::*;

    logic     done_q;
    logic     ctrl_go;
    irq_cnt_t irq_cnt;

    // a start already in flight counts as busy too
    assign ctrl_go = reg_wr_i && (reg_addr_i == REG_CTRL) && reg_wdata_i[0]
                     && !busy_i && !start_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_o   <= '0;
            start_o <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_o <= ctrl_go;
            if (reg_wr_i && reg_addr_i == REG_SRC) begin
                cfg_o.src <= addr_t'(reg_wdata_i);
            end
            if (reg_wr_i && reg_addr_i == REG_DST) begin
                cfg_o.dst <= addr_t'(reg_wdata_i);
            end
            if (reg_wr_i && reg_addr_i == REG_LEN) begin
                cfg_o.len <= len_t'(reg_wdata_i);
            end
            // sticky done, set wins over a clear
            if (fin_i) begin
                done_q <= 1'b1;
            end else if (reg_wr_i && reg_addr_i == REG_STATUS) begin
                done_q <= 1'b0;
            end
        end
    end

    // fin opens the pulse, counter keeps it up
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_cnt <= '0;
        end else if (fin_i) begin
            irq_cnt <= irq_cnt_t'(IRQ_HOLD_CYCLES - 1);
        end else if (irq_cnt != '0) begin
            irq_cnt <= irq_cnt - 1'b1;
        end
    end

    assign irq_o = fin_i || (irq_cnt != '0);

    // combinational register read
    always_comb begin
        reg_rdata_o = '0;
        case (reg_addr_i)
            REG_SRC: reg_rdata_o = data_t'(cfg_o.src);
            REG_DST: reg_rdata_o = data_t'(cfg_o.dst);
            REG_LEN: reg_rdata_o = data_t'(cfg_o.len);
            REG_STATUS: begin
                reg_rdata_o[STATUS_BUSY_BIT] = busy_i;
                reg_rdata_o[STATUS_DONE_BIT] = done_q;
            end
            default: reg_rdata_o = '0;
        endcase
    end

    // engine busy comes back two cycles after the CTRL write
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        !(start_o && busy_i))
        else $error("start issued while engine busy");

endmodule

`default_nettype wire

// ==== verilog/dma_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_engine (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  dma_pkg::dma_cfg_t cfg_i,
    output logic              busy_o,
    output logic              fin_o,
    output bus_pkg::mem_req_t req_o,
    input  logic              credit_i,
    input  bus_pkg::mem_rsp_t rsp_i
);
    import bus_pkg::*;
    import dma_pkg::*;

    dma_state_t state_q;
    dma_cfg_t   cfg_q;
    port_cred_t cred_q;
    len_t       rd_cnt;
    len_t       wr_cnt;
    len_t       ack_cnt;
    len_t       ack_cnt_nx;
    buf_cnt_t   rd_out;
    buf_cnt_t   buf_cnt;
    data_t      buf_q [ENG_BUF_DEPTH];
    logic [ENG_PTR_W-1:0] buf_wr_ptr;
    logic [ENG_PTR_W-1:0] buf_rd_ptr;
    logic       can_issue;
    logic       issue_rd;
    logic       issue_wr;
    logic       rd_rsp;
    logic       wr_ack;

    // only this port's responses are routed here
    assign rd_rsp     = rsp_i.valid && !rsp_i.write;
    assign wr_ack     = rsp_i.valid && rsp_i.write;
    assign ack_cnt_nx = ack_cnt + len_t'(wr_ack);

    // writes drain the buffer first
    assign can_issue = (state_q == DMA_COPY) && (cred_q != '0);
    assign issue_wr  = can_issue && (buf_cnt != '0);
    // reads in flight plus buffered words stay within the buffer
    assign issue_rd  = can_issue && !issue_wr && (rd_cnt < cfg_q.len)
                       && ((rd_out + buf_cnt) < buf_cnt_t'(ENG_BUF_DEPTH));

    // write addresses follow read order, one word each
    always_comb begin
        req_o.valid = issue_rd || issue_wr;
        req_o.write = issue_wr;
        req_o.addr  = issue_wr ? addr_t'(cfg_q.dst + wr_cnt)
                               : addr_t'(cfg_q.src + rd_cnt);
        req_o.data  = buf_q[buf_rd_ptr];
    end

    assign busy_o = (state_q != DMA_IDLE);
    assign fin_o  = (state_q == DMA_FINISH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= DMA_IDLE;
            cred_q     <= port_cred_t'(PORT_CREDITS);
            rd_cnt     <= '0;
            wr_cnt     <= '0;
            ack_cnt    <= '0;
            rd_out     <= '0;
            buf_cnt    <= '0;
            buf_wr_ptr <= '0;
            buf_rd_ptr <= '0;
        end else begin
            // one credit per request, returned by the arbiter
            cred_q  <= cred_q - port_cred_t'(req_o.valid) + port_cred_t'(credit_i);
            rd_out  <= rd_out + buf_cnt_t'(issue_rd) - buf_cnt_t'(rd_rsp);
            buf_cnt <= buf_cnt + buf_cnt_t'(rd_rsp) - buf_cnt_t'(issue_wr);
            if (rd_rsp) begin
                buf_wr_ptr <= buf_wr_ptr + 1'b1;
            end
            if (issue_wr) begin
                buf_rd_ptr <= buf_rd_ptr + 1'b1;
            end
            case (state_q)
                DMA_IDLE: begin
                    if (start_i) begin
                        state_q <= DMA_COPY;
                        rd_cnt  <= '0;
                        wr_cnt  <= '0;
                        ack_cnt <= '0;
                    end
                end
                DMA_COPY: begin
                    if (issue_rd) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                    if (issue_wr) begin
                        wr_cnt <= wr_cnt + 1'b1;
                    end
                    ack_cnt <= ack_cnt_nx;
                    // zero length falls straight through
                    if (ack_cnt_nx == cfg_q.len) begin
                        state_q <= DMA_FINISH;
                    end
                end
                default: state_q <= DMA_IDLE;
            endcase
        end
    end

    // latched config and read data
    always_ff @(posedge clk) begin
        if (start_i && state_q == DMA_IDLE) begin
            cfg_q <= cfg_i;
        end
        if (rd_rsp) begin
            buf_q[buf_wr_ptr] <= rsp_i.data;
        end
    end

    a_cred_bound: assert property (@(posedge clk) disable iff (rst)
        cred_q <= port_cred_t'(PORT_CREDITS))
        else $error("engine holds more credits than slots");

    a_buf_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(rd_rsp && !issue_wr && buf_cnt == buf_cnt_t'(ENG_BUF_DEPTH)))
        else $error("read data buffer overflow");

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  bus_pkg::mem_req_t        host_req_i,
    output logic                     host_credit_o,
    output bus_pkg::mem_rsp_t        host_rsp_o,
    input  bus_pkg::mem_req_t        dma_req_i,
    output logic                     dma_credit_o,
    output bus_pkg::mem_rsp_t        dma_rsp_o,
    output bus_pkg::mem_tagged_req_t mem_req_o,
    input  logic                     mem_credit_i,
    input  bus_pkg::mem_rsp_t        mem_rsp_i
);
    import bus_pkg::*;

    mem_req_t   req_in [NUM_PORTS];
    mem_req_t   slot_q [NUM_PORTS][PORT_CREDITS];
    logic [PORT_PTR_W-1:0] wr_ptr [NUM_PORTS];
    logic [PORT_PTR_W-1:0] rd_ptr [NUM_PORTS];
    port_cred_t slot_cnt [NUM_PORTS];
    logic [NUM_PORTS-1:0] has_req;
    logic [NUM_PORTS-1:0] pop;
    mem_req_t   head;
    mem_cred_t  mem_cred;
    port_t      rr_ptr;
    port_t      sel;
    logic       fwd;

    assign req_in[PORT_HOST] = host_req_i;
    assign req_in[PORT_DMA]  = dma_req_i;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            has_req[p] = (slot_cnt[p] != '0);
        end
        // round robin only when both wait
        if (has_req[PORT_HOST] && has_req[PORT_DMA]) begin
            sel = rr_ptr;
        end else if (has_req[PORT_DMA]) begin
            sel = PORT_DMA;
        end else begin
            sel = PORT_HOST;
        end
        fwd = (has_req != '0) && (mem_cred != '0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            pop[p] = fwd && (sel == port_t'(p));
        end
        head = slot_q[sel][rd_ptr[sel]];
    end

    // forwarded request is tagged with its port
    always_comb begin
        mem_req_o.valid = fwd;
        mem_req_o.write = head.write;
        mem_req_o.port  = sel;
        mem_req_o.addr  = head.addr;
        mem_req_o.data  = head.data;
    end

    // credit goes back as the slot drains
    assign host_credit_o = pop[PORT_HOST];
    assign dma_credit_o  = pop[PORT_DMA];

    // response steering by tag
    always_comb begin
        host_rsp_o       = mem_rsp_i;
        host_rsp_o.valid = mem_rsp_i.valid && (mem_rsp_i.port == PORT_HOST);
        dma_rsp_o        = mem_rsp_i;
        dma_rsp_o.valid  = mem_rsp_i.valid && (mem_rsp_i.port == PORT_DMA);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_ptr[p]   <= '0;
                rd_ptr[p]   <= '0;
                slot_cnt[p] <= '0;
            end
            mem_cred <= mem_cred_t'(MEM_QUEUE_DEPTH);
            rr_ptr   <= PORT_HOST;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (req_in[p].valid) begin
                    wr_ptr[p] <= wr_ptr[p] + 1'b1;
                end
                if (pop[p]) begin
                    rd_ptr[p] <= rd_ptr[p] + 1'b1;
                end
                slot_cnt[p] <= slot_cnt[p] + port_cred_t'(req_in[p].valid)
                               - port_cred_t'(pop[p]);
            end
            mem_cred <= mem_cred - mem_cred_t'(fwd) + mem_cred_t'(mem_credit_i);
            if (fwd) begin
                rr_ptr <= ~sel;
            end
        end
    end

    // slot storage
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (req_in[p].valid) begin
                slot_q[p][wr_ptr[p]] <= req_in[p];
            end
        end
    end

    // requester sent without credit
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_slot_chk
        a_slot_credit: assert property (@(posedge clk) disable iff (rst)
            !(req_in[p].valid && slot_cnt[p] == port_cred_t'(PORT_CREDITS)))
            else $error("port %0d request into a full slot buffer", p);
    end

endmodule

`default_nettype wire

// ==== verilog/shared_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_mem (
    input  logic                     clk,
    input  logic                     rst,
    input  bus_pkg::mem_tagged_req_t req_i,
    output logic                     credit_o,
    output bus_pkg::mem_rsp_t        rsp_o
);
    import bus_pkg::*;

    mem_tagged_req_t queue_q [MEM_QUEUE_DEPTH];
    logic [MEM_PTR_W-1:0] wr_ptr;
    logic [MEM_PTR_W-1:0] rd_ptr;
    mem_cred_t       q_cnt;
    mem_tagged_req_t head;
    data_t           mem_q [MEM_WORDS];
    logic            pop;
    logic            rsp_valid;
    logic            rsp_write;
    port_t           rsp_port;
    data_t           rsp_data;

    // one entry served per cycle
    assign head     = queue_q[rd_ptr];
    assign pop      = (q_cnt != '0);
    assign credit_o = pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_cnt     <= '0;
            rsp_valid <= 1'b0;
        end else begin
            if (req_i.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_cnt     <= q_cnt + mem_cred_t'(req_i.valid) - mem_cred_t'(pop);
            rsp_valid <= pop;
        end
    end

    // queue, array and response payload
    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            queue_q[wr_ptr] <= req_i;
        end
        if (pop) begin
            if (head.write) begin
                mem_q[head.addr] <= head.data;
            end
            rsp_write <= head.write;
            rsp_port  <= head.port;
            // read before write, data unused on an ack
            rsp_data  <= mem_q[head.addr];
        end
    end

    assign rsp_o = '{valid: rsp_valid, write: rsp_write, port: rsp_port, data: rsp_data};

    // arbiter forwarded without a queue credit
    a_queue_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(req_i.valid && q_cnt == mem_cred_t'(MEM_QUEUE_DEPTH)))
        else $error("push into a full request queue");

endmodule

`default_nettype wire

// ==== verilog/dma_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_subsystem (
    input  logic               clk,
    input  logic               rst,
    input  logic               reg_wr_i,
    input  dma_pkg::reg_addr_t reg_addr_i,
    input  bus_pkg::data_t     reg_wdata_i,
    output bus_pkg::data_t     reg_rdata_o,
    input  bus_pkg::mem_req_t  host_req_i,
    output logic               host_credit_o,
    output bus_pkg::mem_rsp_t  host_rsp_o,
    output logic               irq_o
);
    import bus_pkg::*;
    import dma_pkg::*;

    // register block to engine
    logic     start;
    dma_cfg_t cfg;
    logic     busy;
    logic     fin;

    // engine port on the arbiter
    mem_req_t dma_req;
    logic     dma_credit;
    mem_rsp_t dma_rsp;

    // arbiter to memory
    mem_tagged_req_t mem_req;
    logic            mem_credit;
    mem_rsp_t        mem_rsp;

    dma_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_wr_i    (reg_wr_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .busy_i      (busy),
        .fin_i       (fin),
        .start_o     (start),
        .cfg_o       (cfg),
        .irq_o       (irq_o)
    );

    dma_engine u_engine (
        .clk      (clk),
        .rst      (rst),
        .start_i  (start),
        .cfg_i    (cfg),
        .busy_o   (busy),
        .fin_o    (fin),
        .req_o    (dma_req),
        .credit_i (dma_credit),
        .rsp_i    (dma_rsp)
    );

    mem_arbiter u_arb (
        .clk           (clk),
        .rst           (rst),
        .host_req_i    (host_req_i),
        .host_credit_o (host_credit_o),
        .host_rsp_o    (host_rsp_o),
        .dma_req_i     (dma_req),
        .dma_credit_o  (dma_credit),
        .dma_rsp_o     (dma_rsp),
        .mem_req_o     (mem_req),
        .mem_credit_i  (mem_credit),
        .mem_rsp_i     (mem_rsp)
    );

    shared_mem u_mem (
        .clk      (clk),
        .rst      (rst),
        .req_i    (mem_req),
        .credit_o (mem_credit),
        .rsp_o    (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== sim/tb_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dma;
    import bus_pkg::*;
    import dma_pkg::*;

    localparam int CLK_HALF       = 10;
    localparam int RST_CYCLES     = 5;
    localparam int CYCLES_PER_REC = 200;
    localparam int MAX_RECS       = 128;
    localparam int STIM_WORDS     = 3 * MAX_RECS;

    // opcodes of the stimulus file
    localparam data_t OP_END      = 32'h0;
    localparam data_t OP_MEM_WR   = 32'h1;
    localparam data_t OP_MEM_RD   = 32'h2;
    localparam data_t OP_REG_WR   = 32'h3;
    localparam data_t OP_REG_RD   = 32'h4;
    localparam data_t OP_WAIT_IRQ = 32'h5;

    logic      clk;
    logic      rst;
    logic      reg_wr;
    reg_addr_t reg_addr;
    data_t     reg_wdata;
    data_t     reg_rdata;
    mem_req_t  host_req;
    logic      host_credit;
    mem_rsp_t  host_rsp;
    logic      irq;

    // three words per record
    data_t       stim [STIM_WORDS];
    int          n_rec;
    // host slot credits as seen from outside
    int          host_cred;
    // host writes still waiting for their ack
    int          host_wr_pend;
    data_t       rd_data_q [$];
    int          irq_run;
    int          irq_seen;
    len_t        irq_len_last;
    logic [31:0] rng_state;

    dma_subsystem u_dut (
        .clk           (clk),
        .rst           (rst),
        .reg_wr_i      (reg_wr),
        .reg_addr_i    (reg_addr),
        .reg_wdata_i   (reg_wdata),
        .reg_rdata_o   (reg_rdata),
        .host_req_i    (host_req),
        .host_credit_o (host_credit),
        .host_rsp_o    (host_rsp),
        .irq_o         (irq)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: %s gave %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_status(input data_t got, input data_t exp);
        logic [1:0] got_bits;
        logic [1:0] exp_bits;
        got_bits = {got[STATUS_DONE_BIT], got[STATUS_BUSY_BIT]};
        exp_bits = {exp[STATUS_DONE_BIT], exp[STATUS_BUSY_BIT]};
        if (got_bits !== exp_bits) begin
            abort_run($sformatf("Fail at %0d ns: status done,busy %b, expected %b",
                                $time, got_bits, exp_bits));
        end
    endtask

    task automatic check_irq_len(input len_t got, input len_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: interrupt high for %0d cycles, expected %0d",
                                $time, got, exp));
        end
    endtask

    // next drive point, pulses last one cycle
    task automatic step();
        @(posedge clk);
        #1;
        reg_wr         = 1'b0;
        host_req.valid = 1'b0;
    endtask

    task automatic random_gap();
        int n;
        rng_state = xorshift32(rng_state);
        n         = int'(rng_state[1:0]);
        repeat (n) step();
    endtask

    // request goes out only while a slot credit is held
    task automatic host_issue(input logic wr, input addr_t addr, input data_t data);
        random_gap();
        step();
        while (host_cred == 0) begin
            step();
        end
        host_req.valid = 1'b1;
        host_req.write = wr;
        host_req.addr  = addr;
        host_req.data  = data;
        host_cred      = host_cred - 1;
        if (wr) begin
            host_wr_pend = host_wr_pend + 1;
        end
    endtask

    task automatic host_read(input addr_t addr, input data_t exp);
        host_issue(1'b0, addr, '0);
        step();
        while (rd_data_q.size() == 0) begin
            step();
        end
        check_data(rd_data_q.pop_front(), exp, $sformatf("host read of %h", addr));
    endtask

    task automatic reg_write(input reg_addr_t addr, input data_t data);
        step();
        // host traffic reaches the memory queue ahead of the engine
        while (host_cred != PORT_CREDITS) begin
            step();
        end
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
    endtask

    task automatic reg_read(input reg_addr_t addr, input data_t exp);
        step();
        reg_addr = addr;
        // one cycle later a fresh start already shows as busy
        @(posedge clk);
        @(negedge clk);
        if (addr == REG_STATUS) begin
            check_status(reg_rdata, exp);
        end else begin
            check_data(reg_rdata, exp, $sformatf("register %0d read", addr));
        end
    endtask

    task automatic wait_irq(input int count, input len_t exp_len);
        while (irq_seen < count) begin
            step();
        end
        check_irq_len(irq_len_last, exp_len);
    endtask

    // credits, responses and interrupt width, away from the edge
    always @(negedge clk) begin
        if (!rst) begin
            if (host_credit) begin
                host_cred = host_cred + 1;
                if (host_cred > PORT_CREDITS) begin
                    abort_run("host got back more credits than it gave up");
                end
            end
            if (host_rsp.valid && !host_rsp.write) begin
                rd_data_q.push_back(host_rsp.data);
            end
            if (host_rsp.valid && host_rsp.write) begin
                host_wr_pend = host_wr_pend - 1;
                if (host_wr_pend < 0) begin
                    abort_run("host got a write ack for no write");
                end
            end
            if (irq) begin
                irq_run = irq_run + 1;
            end else if (irq_run != 0) begin
                irq_len_last = len_t'(irq_run);
                irq_seen     = irq_seen + 1;
                irq_run      = 0;
            end
        end
    end

    initial begin
        @(negedge rst);
        repeat (n_rec * CYCLES_PER_REC) @(posedge clk);
        abort_run("watchdog expired before the stimulus file was done");
    end

    initial begin
        data_t op;
        data_t arg_a;
        data_t arg_b;
        rst          = 1'b1;
        reg_wr       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        host_req     = '0;
        host_cred    = PORT_CREDITS;
        host_wr_pend = 0;
        irq_run      = 0;
        irq_seen     = 0;
        irq_len_last = '0;
        rng_state    = 32'd83;
        n_rec        = 0;
        for (int i = 0; i < STIM_WORDS; i++) begin
            stim[i] = '0;
        end
        $readmemh("sim/dma_stimulus.txt", stim);
        while (n_rec < MAX_RECS && stim[3 * n_rec] != OP_END) begin
            n_rec++;
        end
        if (n_rec == 0 || n_rec == MAX_RECS) begin
            abort_run("stimulus file is missing, empty or has no end record");
        end
        // end record included
        n_rec++;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < n_rec; r++) begin
            op    = stim[3 * r];
            arg_a = stim[3 * r + 1];
            arg_b = stim[3 * r + 2];
            case (op)
                OP_MEM_WR:   host_issue(1'b1, addr_t'(arg_a), arg_b);
                OP_MEM_RD:   host_read(addr_t'(arg_a), arg_b);
                OP_REG_WR:   reg_write(reg_addr_t'(arg_a), arg_b);
                OP_REG_RD:   reg_read(reg_addr_t'(arg_a), arg_b);
                OP_WAIT_IRQ: wait_irq(int'(arg_a), len_t'(arg_b));
                // total number of interrupts over the run
                OP_END:      check_data(data_t'(irq_seen), arg_b, "interrupt count");
                default:     abort_run($sformatf("unknown opcode %h in record %0d", op, r));
            endcase
        end
        // every host write acked, no stray read data
        check_data(data_t'(host_wr_pend), '0, "pending host write acks");
        check_data(data_t'(rd_data_q.size()), '0, "unclaimed host read responses");
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/dma_stimulus.txt ====
// columns: opcode, address or register index, data or expected value
// 1 mem wr, 2 mem rd, 3 reg wr, 4 reg rd, 5 wait irq (count, length), 0 end (irq total)
1 040 9e3779b9
1 041 7f4a7c15
1 042 c2b2ae35
1 043 27d4eb2f
1 044 165667b1
1 045 d3a2646c
1 046 fd7046c5
1 047 b55a4f09
3 0 00000040
3 1 00000080
3 2 00000008
3 3 00000001
4 4 00000001
1 300 0badf00d
1 301 600dcafe
2 300 0badf00d
1 300 12345678
2 301 600dcafe
2 300 12345678
4 2 00000008
5 1 00000003
4 4 00000002
2 080 9e3779b9
2 081 7f4a7c15
2 082 c2b2ae35
2 083 27d4eb2f
2 084 165667b1
2 085 d3a2646c
2 086 fd7046c5
2 087 b55a4f09
3 4 00000000
4 4 00000000
1 0e0 5a5a00e0
3 0 00000040
3 1 000000c0
3 2 00000002
3 3 00000001
3 0 00000044
3 1 000000e0
3 2 00000004
3 3 00000001
5 2 00000003
2 0c0 9e3779b9
2 0c1 7f4a7c15
2 0e0 5a5a00e0
3 4 00000000
3 2 00000000
3 3 00000001
5 3 00000003
4 4 00000002
2 0e0 5a5a00e0
0 0 00000003

// ==== tb.f ====
verilog/bus_pkg.sv
verilog/dma_pkg.sv
verilog/dma_regs.sv
verilog/dma_engine.sv
verilog/mem_arbiter.sv
verilog/shared_mem.sv
verilog/dma_subsystem.sv
sim/tb_dma.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the DMA testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module tb_dma \
    -f tb.f \
    -o sim_tb_dma

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/sim_tb_dma
